// ==== source/isaPkg.sv ====
package isaPkg;

    // Data, address and instruction width
    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] dataT;

    ////////////////////////////////
    // Low nibble of an instruction byte
    // Codes not listed here end the thread like opGotoIdle
    typedef enum logic [3:0] {
        opReadA    = 4'd0,
        opReadB    = 4'd1,
        opWriteA   = 4'd2,
        opWriteB   = 4'd3,
        opMathsA   = 4'd4,
        opMathsB   = 4'd5,
        opBranchIf = 4'd6,
        opGoto     = 4'd7,
        opGotoIdle = 4'd8,
        opLoadImmA = 4'd13,
        opLoadImmB = 4'd14
    } opcodeE;

    ////////////////////////////////
    // High nibble, ALU function
    typedef enum logic [3:0] {
        aluAdd       = 4'd0,
        aluSub       = 4'd1,
        aluMul       = 4'd2,
        aluShiftLeft = 4'd3,
        aluShiftRight = 4'd4,
        aluIncA      = 4'd5,
        aluIncB      = 4'd6,
        aluDecA      = 4'd7,
        aluDecB      = 4'd8,
        aluEqual     = 4'd9,
        aluGreater   = 4'd10,
        aluLess      = 4'd11
    } aluFuncE;

    ////////////////////////////////
    // Sequencer states, grouped by high nibble per instruction
    typedef enum logic [7:0] {
        stChooseOp = 8'h00,
        stRead0    = 8'h10,
        stRead1    = 8'h11,
        stRead2    = 8'h12,
        stRead3    = 8'h13,
        stWrite0   = 8'h20,
        stWrite1   = 8'h21,
        stMaths0   = 8'h30,
        stMaths1   = 8'h31,
        stBranch0  = 8'h40,
        stBranch1  = 8'h41,
        stGoto0    = 8'h50,
        stGoto1    = 8'h51,
        stGoto2    = 8'h52,
        stLoadImm0 = 8'h80,
        stLoadImm1 = 8'h81,
        stIdle     = 8'hF0,
        stThread0  = 8'hF1,
        stThread1  = 8'hF2,
        stThread2  = 8'hF3
    } stateE;

    // Register write-back source
    typedef enum logic [1:0] {
        wbBus = 2'd0,
        wbAlu = 2'd1,
        wbRom = 2'd2
    } wbSrcE;

endpackage

// ==== source/systemPkg.sv ====
package systemPkg;

    import isaPkg::*;

    ////////////////////////////////
    // Data bus map
    // Address parked on the bus between accesses
    localparam dataT idleBusAddr = 8'hFF;

    ////////////////////////////////
    // Interrupts
    localparam int interruptCount = 2;

    // ROM bytes holding the thread start address of each line
    // Line 0 is the higher priority line
    localparam dataT vectorAddrA = 8'hFF;
    localparam dataT vectorAddrB = 8'hFE;

    ////////////////////////////////
    // Reset values
    // First instruction decoded after reset
    localparam dataT resetPc = 8'h00;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
    import isaPkg::*;
(
    // Operands straight from the register bank
    input  dataT    inA,
    input  dataT    inB,
    // High nibble of the current instruction byte
    input  aluFuncE func,
    output dataT    result
);

    // Full product, only the low byte is kept
    logic [2*dataWidth-1:0] product;

    assign product = inA * inB;

    always_comb begin
        case (func)
            // Arithmetic
            aluAdd: result = inA + inB;
            aluSub: result = inA - inB;
            aluMul: result = product[dataWidth-1:0];

            // Single bit shifts of A
            aluShiftLeft: result = inA << 1;
            aluShiftRight: result = inA >> 1;

            // Increment and decrement
            aluIncA: result = inA + 8'd1;
            aluIncB: result = inB + 8'd1;
            aluDecA: result = inA - 8'd1;
            aluDecB: result = inB - 8'd1;

            // Compares give 1 or 0, used by the branch test
            aluEqual: begin
                result = (inA == inB) ? 8'd1 : 8'd0;
            end
            aluGreater: begin
                result = (inA > inB) ? 8'd1 : 8'd0;
            end
            aluLess: begin
                result = (inA < inB) ? 8'd1 : 8'd0;
            end

            // Unused codes
            default: result = '0;
        endcase
    end

endmodule

// ==== source/registerBank.sv ====
`timescale 1ns/1ps

module registerBank
    import isaPkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    // Write-back request from the sequencer
    input  logic  wbEnable,
    input  logic  wbSelB,
    input  wbSrcE wbSrc,
    // Candidate sources
    input  dataT  busDataIn,
    input  dataT  aluResult,
    input  dataT  romData,
    // Working registers
    output dataT  regA,
    output dataT  regB
);

    dataT wbData;

    ////////////////////////////////
    // Source select
    always_comb begin
        case (wbSrc)
            wbBus: wbData = busDataIn;
            wbAlu: wbData = aluResult;
            wbRom: wbData = romData;
            default: wbData = '0;
        endcase
    end

    ////////////////////////////////
    // Registers A and B
    // Only the selected register loads on the strobe edge
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else if (wbEnable) begin
            if (wbSelB) begin
                regB <= wbData;
            end else begin
                regA <= wbData;
            end
        end
    end

endmodule

// ==== source/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer
    import isaPkg::*;
    import systemPkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    // Program ROM, one cycle registered read
    output dataT                      romAddress,
    input  dataT                      romData,
    // Data bus
    output dataT                      busAddr,
    output dataT                      busDataOut,
    output logic                      busWe,
    // Interrupt lines
    input  logic [interruptCount-1:0] interruptRaise,
    output logic [interruptCount-1:0] interruptAck,
    // ALU and register bank
    input  dataT                      aluResult,
    input  dataT                      regA,
    input  dataT                      regB,
    output aluFuncE                   aluFunc,
    output logic                      wbEnable,
    output logic                      wbSelB,
    output wbSrcE                     wbSrc
);

    stateE state;
    stateE nextState;
    dataT pc;
    dataT nextPc;
    // Offset 1 fetches the operand byte after the opcode
    logic pcOffset;
    logic nextPcOffset;
    dataT busAddrReg;
    dataT nextBusAddr;
    // Register targeted by the current instruction, 1 is B
    logic regSel;
    logic nextRegSel;
    logic [interruptCount-1:0] ackReg;
    logic [interruptCount-1:0] nextAck;
    opcodeE opcode;

    ////////////////////////////////
    // Fixed decode of the ROM byte
    assign opcode = opcodeE'(romData[3:0]);
    assign aluFunc = aluFuncE'(romData[7:4]);
    assign romAddress = pc + dataT'(pcOffset);

    // Write drives address and strobe in its last cycle
    // Operand byte arrives from ROM in that same cycle
    assign busAddr = (state == stWrite1) ? romData : busAddrReg;
    assign busWe = (state == stWrite1);
    assign busDataOut = regSel ? regB : regA;
    assign interruptAck = ackReg;
    assign wbSelB = regSel;

    ////////////////////////////////
    // Write-back requests
    always_comb begin
        wbEnable = 1'b0;
        wbSrc = wbAlu;
        case (state)
            stRead3: begin
                wbEnable = 1'b1;
                wbSrc = wbBus;
            end
            stMaths0: begin
                wbEnable = 1'b1;
                wbSrc = wbAlu;
            end
            stLoadImm1: begin
                wbEnable = 1'b1;
                wbSrc = wbRom;
            end
            default: begin
                wbEnable = 1'b0;
            end
        endcase
    end

    ////////////////////////////////
    // State registers
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= stChooseOp;
            pc <= resetPc;
            pcOffset <= 1'b0;
            busAddrReg <= idleBusAddr;
            regSel <= 1'b0;
            ackReg <= '0;
        end else begin
            state <= nextState;
            pc <= nextPc;
            pcOffset <= nextPcOffset;
            busAddrReg <= nextBusAddr;
            regSel <= nextRegSel;
            ackReg <= nextAck;
        end
    end

    ////////////////////////////////
    // Next state logic
    always_comb begin
        // Defaults hold the thread and park the bus
        nextState = state;
        nextPc = pc;
        nextPcOffset = 1'b0;
        nextBusAddr = idleBusAddr;
        nextRegSel = regSel;
        nextAck = '0;

        case (state)
            // Wait for an interrupt, line 0 first
            stIdle: begin
                if (interruptRaise[0]) begin
                    nextState = stThread0;
                    nextPc = vectorAddrA;
                    nextAck[0] = 1'b1;
                end else if (interruptRaise[1]) begin
                    nextState = stThread0;
                    nextPc = vectorAddrB;
                    nextAck[1] = 1'b1;
                end
            end
            // Vector byte on its way from ROM
            stThread0: nextState = stThread1;
            stThread1: begin
                nextState = stThread2;
                nextPc = romData;
            end
            // New address goes out to ROM
            stThread2: nextState = stChooseOp;

            // Decode, operand byte is fetched next
            stChooseOp: begin
                nextPcOffset = 1'b1;
                nextRegSel = opcode inside {opReadB, opWriteB, opMathsB, opLoadImmB};
                case (opcode)
                    opReadA, opReadB: nextState = stRead0;
                    opWriteA, opWriteB: nextState = stWrite0;
                    opMathsA, opMathsB: nextState = stMaths0;
                    opBranchIf: nextState = stBranch0;
                    opGoto: nextState = stGoto0;
                    opLoadImmA, opLoadImmB: nextState = stLoadImm0;
                    // Goto idle and all unused codes
                    default: nextState = stIdle;
                endcase
            end

            ////////////////////////////////
            // Memory read
            stRead0: nextState = stRead1;
            stRead1: begin
                nextState = stRead2;
                nextBusAddr = romData;
            end
            // RAM samples the address here
            stRead2: begin
                nextState = stRead3;
                nextPc = pc + 8'd2;
            end
            // Bus data loads into the register
            stRead3: nextState = stChooseOp;

            // Memory write
            stWrite0: begin
                nextState = stWrite1;
                nextPc = pc + 8'd2;
            end
            stWrite1: nextState = stChooseOp;

            // ALU result is ready in the first cycle
            stMaths0: begin
                nextState = stMaths1;
                nextPc = pc + 8'd1;
            end
            stMaths1: nextState = stChooseOp;

            ////////////////////////////////
            // Branch on a nonzero compare
            stBranch0: begin
                if (aluResult != '0) begin
                    // Target byte already requested
                    nextState = stGoto1;
                end else begin
                    nextState = stBranch1;
                    nextPc = pc + 8'd2;
                end
            end
            stBranch1: nextState = stChooseOp;

            // Goto
            stGoto0: nextState = stGoto1;
            stGoto1: begin
                nextState = stGoto2;
                nextPc = romData;
            end
            stGoto2: nextState = stChooseOp;

            // Load immediate from the operand byte
            stLoadImm0: begin
                nextState = stLoadImm1;
                nextPc = pc + 8'd2;
            end
            stLoadImm1: nextState = stChooseOp;

            default: nextState = stIdle;
        endcase
    end

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop
    import isaPkg::*;
    import systemPkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    // Program ROM
    output dataT                      romAddress,
    input  dataT                      romData,
    // Data bus with split data lines
    output dataT                      busAddr,
    input  dataT                      busDataIn,
    output dataT                      busDataOut,
    output logic                      busWe,
    // Interrupt handshake
    input  logic [interruptCount-1:0] interruptRaise,
    output logic [interruptCount-1:0] interruptAck
);

    dataT    regA;
    dataT    regB;
    dataT    aluResult;
    aluFuncE aluFunc;
    logic    wbEnable;
    logic    wbSelB;
    wbSrcE   wbSrc;

    // Sequencing, bus and interrupt control
    controlSequencer sequencer (
        .CLK(CLK),
        .RESET(RESET),
        .romAddress(romAddress),
        .romData(romData),
        .busAddr(busAddr),
        .busDataOut(busDataOut),
        .busWe(busWe),
        .interruptRaise(interruptRaise),
        .interruptAck(interruptAck),
        .aluResult(aluResult),
        .regA(regA),
        .regB(regB),
        .aluFunc(aluFunc),
        .wbEnable(wbEnable),
        .wbSelB(wbSelB),
        .wbSrc(wbSrc)
    );

    alu mathUnit (
        .inA(regA),
        .inB(regB),
        .func(aluFunc),
        .result(aluResult)
    );

    // Bus data goes straight to the registers
    registerBank registers (
        .CLK(CLK),
        .RESET(RESET),
        .wbEnable(wbEnable),
        .wbSelB(wbSelB),
        .wbSrc(wbSrc),
        .busDataIn(busDataIn),
        .aluResult(aluResult),
        .romData(romData),
        .regA(regA),
        .regB(regB)
    );

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic CLK,
    output logic RESET
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Reset held over the first two rising edges
    initial begin
        RESET <= 1'b1;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb
    import isaPkg::*;
    import systemPkg::*;
();

    localparam int rowCount = 5;
    localparam int resetTimeout = 10;
    localparam int ackTimeout = 200;
    localparam int writeTimeout = 200;
    localparam int drainCycles = 40;

    // One interrupt thread per row
    // Up to three {address, data} write pairs with the first pair in the top bits
    typedef struct packed {
        logic [1:0]  raise;
        logic [1:0]  ack;
        dataT        vectorA;
        dataT        vectorB;
        dataT        preAddr;
        dataT        preData;
        logic [1:0]  writeCount;
        logic [47:0] writes;
    } rowT;

    logic CLK;
    logic RESET;
    dataT romAddress;
    dataT romData;
    dataT busAddr;
    dataT busDataIn;
    dataT busDataOut;
    logic busWe;
    logic [interruptCount-1:0] interruptRaise;
    logic [interruptCount-1:0] interruptAck;

    dataT rom [0:255];
    dataT ram [0:255];
    // Every write strobe seen on the bus with the oldest first
    dataT writeAddrQ [$];
    dataT writeDataQ [$];
    rowT rows [rowCount];
    integer seed;
    int errorCount;
    int checkCount;
    logic timedOut;

    clockGen clocks (
        .CLK(CLK),
        .RESET(RESET)
    );

    cpuTop uut (
        .CLK(CLK),
        .RESET(RESET),
        .romAddress(romAddress),
        .romData(romData),
        .busAddr(busAddr),
        .busDataIn(busDataIn),
        .busDataOut(busDataOut),
        .busWe(busWe),
        .interruptRaise(interruptRaise),
        .interruptAck(interruptAck)
    );

    ////////////////////////////////
    // Program ROM returns the byte addressed on the previous edge
    initial begin
        romData <= '0;
        forever begin
            @(posedge CLK);
            romData <= rom[romAddress];
        end
    end

    // Data RAM reads before it writes and logs each strobe
    initial begin
        busDataIn <= '0;
        forever begin
            @(posedge CLK);
            busDataIn <= ram[busAddr];
            if (busWe) begin
                ram[busAddr] = busDataOut;
                writeAddrQ.push_back(busAddr);
                writeDataQ.push_back(busDataOut);
            end
        end
    end

    ////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // First byte of the code sits in the top used bits
    task automatic placeCode(input dataT start, input logic [127:0] code, input int len);
        for (int i = 0; i < len; i++) begin
            rom[start + dataT'(i)] = code[8*(len-1-i) +: 8];
        end
    endtask

    task automatic fillMemories();
        dataT idx;
        seed = 32'h868b0bf0;
        for (int i = 0; i < 256; i++) begin
            idx = dataT'(i);
            // Goto idle everywhere with the whole address folded into the high nibble
            rom[idx] = {idx[7:4] ^ idx[3:0], 4'h8};
            ram[idx] = dataT'($random(seed));
        end
    endtask

    task automatic loadPrograms();
        // Reset entry holds goto idle
        placeCode(8'h00, 128'h08, 1);
        // LDA 7, LDB 5, ADD A, WRA 10, SUB B, WRB 11, LDB 5, MUL A, WRA 12, idle
        placeCode(8'h10, 128'h0D07_0E05_04_0210_15_0311_0E05_24_0212_08, 16);
        // RDA 20, INC A, SHL A, WRA 21, idle
        placeCode(8'h30, 128'h0020_54_34_0221_08, 7);
        // LDA 3, LDB 3, BEQ 4C, fall-through marker E1 to 30, idle, pad
        placeCode(8'h40, 128'h0D03_0E03_964C_0EE1_0330_08_08, 12);
        // Marker A1 to 31, LDB 2, BLT 5C, fall-through marker A2 to 32, idle
        placeCode(8'h4C, 128'h0EA1_0331_0E02_B65C_0EA2_0332_08, 13);
        // Branch target is never reached and writes marker E2 to 33
        placeCode(8'h5C, 128'h0EE2_0333_08, 5);
        // GOTO 74 over WRA 3F, then LDA 5A, WRA 34, idle
        placeCode(8'h70, 128'h0774_023F_0D5A_0234_08, 9);
        // Line 1 thread of the priority test runs LDA 6B, WRA 35, idle
        placeCode(8'h80, 128'h0D6B_0235_08, 5);
    endtask

    ////////////////////////////////
    // Raise, ack, vectors, preload, write count, writes
    task automatic buildTable();
        // 7+5=12, 12-5=7, 12*5=60
        rows[0] = '{2'b01, 2'b01, 8'h10, 8'h30, 8'h20, 8'h9F, 2'd3,
                    {16'h100C, 16'h1107, 16'h123C}};
        // (9F+1)<<1 keeps the low byte 40
        rows[1] = '{2'b10, 2'b10, 8'h10, 8'h30, 8'h20, 8'h9F, 2'd1,
                    {16'h2140, 16'h0, 16'h0}};
        // 3==3 taken, 3<2 not taken
        rows[2] = '{2'b01, 2'b01, 8'h40, 8'h30, 8'h20, 8'h9F, 2'd2,
                    {16'h31A1, 16'h32A2, 16'h0}};
        // Both lines at once with line 0 first
        rows[3] = '{2'b11, 2'b01, 8'h70, 8'h80, 8'h20, 8'h9F, 2'd1,
                    {16'h345A, 16'h0, 16'h0}};
        // Line 1 still held from the row before
        rows[4] = '{2'b00, 2'b10, 8'h70, 8'h80, 8'h20, 8'h9F, 2'd1,
                    {16'h356B, 16'h0, 16'h0}};
    endtask

    ////////////////////////////////
    task automatic waitAck(output logic [interruptCount-1:0] seen);
        int cycles;
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (interruptAck == '0 && cycles < ackTimeout);
        seen = interruptAck;
        if (seen == '0) begin
            $display("Timeout: no interrupt acknowledge within %0d cycles", ackTimeout);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    // Caller sits on a falling edge
    task automatic waitWrite(output dataT addr, output dataT data);
        int cycles;
        cycles = 0;
        addr = '0;
        data = '0;
        while (writeAddrQ.size() == 0 && cycles < writeTimeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (writeAddrQ.size() == 0) begin
            $display("Timeout: expected bus write missing after %0d cycles", writeTimeout);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            addr = writeAddrQ.pop_front();
            data = writeDataQ.pop_front();
        end
    endtask

    task automatic runRow(input int r);
        logic [interruptCount-1:0] seen;
        dataT addr;
        dataT data;
        logic [15:0] pair;
        rom[vectorAddrA] = rows[r].vectorA;
        rom[vectorAddrB] = rows[r].vectorB;
        ram[rows[r].preAddr] = rows[r].preData;
        @(posedge CLK);
        interruptRaise <= interruptRaise | rows[r].raise;
        waitAck(seen);
        if (!timedOut) begin
            checkValue("interruptAck", 32'(seen), 32'(rows[r].ack));
            // Peripheral drops the line once it sees its ack
            @(posedge CLK);
            interruptRaise <= interruptRaise & ~seen;
            @(negedge CLK);
            // Ack lasts one cycle only
            checkValue("interruptAck", 32'(interruptAck), 0);
            for (int w = 0; w < int'(rows[r].writeCount) && !timedOut; w++) begin
                pair = rows[r].writes[47-16*w -: 16];
                waitWrite(addr, data);
                if (!timedOut) begin
                    checkValue("busAddr", 32'(addr), 32'(pair[15:8]));
                    checkValue("busDataOut", 32'(data), 32'(pair[7:0]));
                end
            end
        end
    endtask

    ////////////////////////////////
    initial begin
        int cycles;
        interruptRaise <= '0;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        cycles = 0;
        fillMemories();
        loadPrograms();
        buildTable();

        do begin
            @(negedge CLK);
            cycles++;
        end while (RESET && cycles < resetTimeout);
        if (RESET) begin
            $display("Timeout: reset still asserted after %0d cycles", resetTimeout);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            // Bus parked, no ack, no write before the first interrupt
            checkValue("busWe", 32'(busWe), 0);
            checkValue("interruptAck", 32'(interruptAck), 0);
            checkValue("busAddr", 32'(busAddr), 32'h0000_00FF);
            // First fetch comes from address 0
            checkValue("romAddress", 32'(romAddress), 32'h0000_0000);
            repeat (8) @(negedge CLK);
            checkValue("write count", 32'(writeAddrQ.size()), 0);
        end

        for (int r = 0; r < rowCount && !timedOut; r++) begin
            runRow(r);
        end

        // Skipped writes of untaken paths would show up here
        if (!timedOut) begin
            repeat (drainCycles) @(negedge CLK);
            checkValue("extra writes", 32'(writeAddrQ.size()), 0);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/isaPkg.sv
source/systemPkg.sv
source/alu.sv
source/registerBank.sv
source/controlSequencer.sv
source/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module cpuTb -f build.f
output=$(./obj_dir/VcpuTb)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
